// ==== hw/mmu_defines.svh ====
// MMU sizing and segment constants, include wherever TLB size or kseg bounds are needed
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// joint TLB size
`define MMU_TLB_ENTRIES 16
`define MMU_INDEX_W     4

// unmapped kernel segments, kseg0 then kseg1
`define MMU_KSEG0_BASE  32'h8000_0000
`define MMU_KSEG1_BASE  32'hA000_0000
`define MMU_KSEG1_END   32'hBFFF_FFFF

// 4 KB pages only
`define MMU_PAGE_BITS   12

`endif

// ==== hw/tlb_entry_pkg.sv ====
// address and TLB entry types, imported by the TLB array, the MMU top level and the testbench
`default_nettype none
`include "mmu_defines.svh"

package tlb_entry_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    typedef logic [18:0] vpn2_t;   // even/odd page pair
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;

    typedef logic [`MMU_INDEX_W-1:0] tlb_index_t;

    // one page half, entry-lo layout
    typedef struct packed {
        pfn_t       pfn;
        logic [2:0] c;   // cache attribute, passed through
        logic       d;   // dirty, store allowed
        logic       v;
        logic       g;
    } tlb_lo_t;

endpackage

`default_nettype wire

// ==== hw/tlb_op_pkg.sv ====
// TLB instruction codes and operation FSM states, used by the op FSM, the top level and testbench
`default_nettype none

package tlb_op_pkg;

    typedef enum logic [1:0] {
        TLB_OP_READ         = 2'd0,
        TLB_OP_WRITE_INDEX  = 2'd1,
        TLB_OP_WRITE_RANDOM = 2'd2,
        TLB_OP_PROBE        = 2'd3
    } tlb_op_t;

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_EXEC,
        OP_ACK
    } tlb_op_state_t;

endpackage

`default_nettype wire

// ==== hw/tlb.sv ====
// joint TLB array, two combinational search ports, clocked write port and combinational read port
`timescale 1ns/1ns
`default_nettype none
`include "mmu_defines.svh"

module tlb (
    input  logic                      clk,
    input  logic                      reset,
    // search port 0, instruction side
    input  tlb_entry_pkg::vpn2_t      s0_vpn2,
    input  logic                      s0_odd,
    input  tlb_entry_pkg::asid_t      s0_asid,
    output logic                      s0_found,
    output tlb_entry_pkg::tlb_index_t s0_index,
    output tlb_entry_pkg::tlb_lo_t    s0_lo,
    // search port 1, data side and probe
    input  tlb_entry_pkg::vpn2_t      s1_vpn2,
    input  logic                      s1_odd,
    input  tlb_entry_pkg::asid_t      s1_asid,
    output logic                      s1_found,
    output tlb_entry_pkg::tlb_index_t s1_index,
    output tlb_entry_pkg::tlb_lo_t    s1_lo,
    // write port
    input  logic                      we,
    input  tlb_entry_pkg::tlb_index_t w_index,
    input  tlb_entry_pkg::vpn2_t      w_vpn2,
    input  tlb_entry_pkg::asid_t      w_asid,
    input  logic                      w_g,
    input  tlb_entry_pkg::tlb_lo_t    w_lo0,
    input  tlb_entry_pkg::tlb_lo_t    w_lo1,
    // read port
    input  tlb_entry_pkg::tlb_index_t r_index,
    output tlb_entry_pkg::vpn2_t      r_vpn2,
    output tlb_entry_pkg::asid_t      r_asid,
    output logic                      r_g,
    output tlb_entry_pkg::tlb_lo_t    r_lo0,
    output tlb_entry_pkg::tlb_lo_t    r_lo1
);
    import tlb_entry_pkg::*;

    localparam int entries = `MMU_TLB_ENTRIES;

    vpn2_t              vpn2_q [entries];
    asid_t              asid_q [entries];
    logic [entries-1:0] g_q;
    tlb_lo_t            lo0_q [entries];
    tlb_lo_t            lo1_q [entries];

    logic [entries-1:0] s0_hit;
    logic [entries-1:0] s1_hit;

    // lowest matching entry wins
    function automatic tlb_index_t encode(input logic [entries-1:0] hits);
        tlb_index_t idx;
        idx = '0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (hits[i]) begin
                idx = tlb_index_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < entries; i++) begin
            s0_hit[i] = (vpn2_q[i] == s0_vpn2) && (g_q[i] || asid_q[i] == s0_asid);
            s1_hit[i] = (vpn2_q[i] == s1_vpn2) && (g_q[i] || asid_q[i] == s1_asid);
        end
    end

    assign s0_found = |s0_hit;
    assign s0_index = encode(s0_hit);
    assign s0_lo    = s0_odd ? lo1_q[s0_index] : lo0_q[s0_index];

    assign s1_found = |s1_hit;
    assign s1_index = encode(s1_hit);
    assign s1_lo    = s1_odd ? lo1_q[s1_index] : lo0_q[s1_index];

    // entries come out of reset invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                vpn2_q[i] <= '0;
                asid_q[i] <= '0;
                g_q[i]    <= 1'b0;
                lo0_q[i]  <= '0;
                lo1_q[i]  <= '0;
            end
        end else if (we) begin
            vpn2_q[w_index] <= w_vpn2;
            asid_q[w_index] <= w_asid;
            g_q[w_index]    <= w_g;
            lo0_q[w_index]  <= w_lo0;
            lo1_q[w_index]  <= w_lo1;
        end
    end

    assign r_vpn2 = vpn2_q[r_index];
    assign r_asid = asid_q[r_index];
    assign r_g    = g_q[r_index];
    assign r_lo0  = lo0_q[r_index];
    assign r_lo1  = lo1_q[r_index];

endmodule

`default_nettype wire

// ==== hw/tlb_random.sv ====
// free-running random index for TLBWR, counts down from the last entry to the wired bound
`timescale 1ns/1ns
`default_nettype none
`include "mmu_defines.svh"

module tlb_random (
    input  logic                      clk,
    input  logic                      reset,
    input  tlb_entry_pkg::tlb_index_t wired,
    input  logic                      wired_write,
    output tlb_entry_pkg::tlb_index_t random_index
);
    import tlb_entry_pkg::*;

    localparam tlb_index_t last_index = tlb_index_t'(`MMU_TLB_ENTRIES - 1);

    // wraps back to the top once the wired bound is reached
    always_ff @(posedge clk) begin
        if (reset || wired_write) begin
            random_index <= last_index;
        end else if (random_index <= wired) begin
            random_index <= last_index;
        end else begin
            random_index <= random_index - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tlb_op_fsm.sv ====
// sequencer for TLBR, TLBWI, TLBWR and TLBP over the four-phase req/ack handshake
`timescale 1ns/1ns
`default_nettype none

module tlb_op_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      op_req,
    input  tlb_op_pkg::tlb_op_t       op_code,
    input  tlb_entry_pkg::tlb_index_t cp0_index,
    input  tlb_entry_pkg::tlb_index_t random_index,
    // from the array
    input  logic                      s1_found,
    input  tlb_entry_pkg::tlb_index_t s1_index,
    input  tlb_entry_pkg::vpn2_t      r_vpn2,
    input  tlb_entry_pkg::asid_t      r_asid,
    input  logic                      r_g,
    input  tlb_entry_pkg::tlb_lo_t    r_lo0,
    input  tlb_entry_pkg::tlb_lo_t    r_lo1,
    // to the array
    output logic                      we,
    output tlb_entry_pkg::tlb_index_t w_index,
    output logic                      probe_sel,
    output logic                      op_ack,
    // results, stable while op_ack is high
    output tlb_entry_pkg::vpn2_t      rd_vpn2,
    output tlb_entry_pkg::asid_t      rd_asid,
    output tlb_entry_pkg::tlb_lo_t    rd_lo0,
    output tlb_entry_pkg::tlb_lo_t    rd_lo1,
    output logic                      probe_hit,
    output tlb_entry_pkg::tlb_index_t probe_index
);
    import tlb_op_pkg::*;

    tlb_op_state_t state;
    logic          exec;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= OP_IDLE;
        end else begin
            case (state)
                OP_IDLE: if (op_req) state <= OP_EXEC;
                OP_EXEC: state <= OP_ACK;
                OP_ACK:  if (!op_req) state <= OP_IDLE;
                default: state <= OP_IDLE;
            endcase
        end
    end

    assign exec      = (state == OP_EXEC);
    assign op_ack    = (state == OP_ACK);
    assign probe_sel = exec && (op_code == TLB_OP_PROBE); // steer data search to entry-hi

    // write commits on the edge leaving exec
    assign we      = exec && (op_code == TLB_OP_WRITE_INDEX || op_code == TLB_OP_WRITE_RANDOM);
    assign w_index = (op_code == TLB_OP_WRITE_RANDOM) ? random_index : cp0_index;

    always_ff @(posedge clk) begin
        if (exec && op_code == TLB_OP_READ) begin
            rd_vpn2 <= r_vpn2;
            rd_asid <= r_asid;
            rd_lo0  <= '{pfn: r_lo0.pfn, c: r_lo0.c, d: r_lo0.d, v: r_lo0.v, g: r_g};
            rd_lo1  <= '{pfn: r_lo1.pfn, c: r_lo1.c, d: r_lo1.d, v: r_lo1.v, g: r_g};
        end
        if (probe_sel) begin
            probe_hit   <= s1_found;
            probe_index <= s1_index;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tlb_mmu.sv ====
// MMU top level, translates fetch and data addresses and runs the TLB instructions from CP0
`timescale 1ns/1ns
`default_nettype none
`include "mmu_defines.svh"

module tlb_mmu (
    input  logic                      clk,
    input  logic                      reset,
    input  tlb_entry_pkg::vaddr_t     inst_vaddr,
    input  tlb_entry_pkg::vaddr_t     data_vaddr,
    input  logic                      data_store,
    input  logic                      op_req,
    input  tlb_op_pkg::tlb_op_t       op_code,
    input  tlb_entry_pkg::tlb_index_t cp0_index,
    input  tlb_entry_pkg::vpn2_t      cp0_vpn2,
    input  tlb_entry_pkg::asid_t      cp0_asid,
    input  tlb_entry_pkg::tlb_lo_t    cp0_lo0,
    input  tlb_entry_pkg::tlb_lo_t    cp0_lo1,
    input  tlb_entry_pkg::tlb_index_t cp0_wired,
    input  logic                      wired_write,
    output tlb_entry_pkg::paddr_t     inst_paddr,
    output logic                      inst_miss,
    output logic                      inst_invalid,
    output tlb_entry_pkg::paddr_t     data_paddr,
    output logic                      data_miss,
    output logic                      data_invalid,
    output logic                      data_modify,
    output logic                      op_ack,
    output tlb_entry_pkg::vpn2_t      rd_vpn2,
    output tlb_entry_pkg::asid_t      rd_asid,
    output tlb_entry_pkg::tlb_lo_t    rd_lo0,
    output tlb_entry_pkg::tlb_lo_t    rd_lo1,
    output logic                      probe_hit,
    output tlb_entry_pkg::tlb_index_t probe_index
);
    import tlb_entry_pkg::*;

    logic       s0_found, s1_found;
    tlb_index_t s1_index;
    tlb_lo_t    s0_lo, s1_lo;
    vpn2_t      s1_vpn2;
    logic       we, probe_sel, r_g;
    tlb_index_t w_index, random_index;
    vpn2_t      r_vpn2;
    asid_t      r_asid;
    tlb_lo_t    r_lo0, r_lo1;
    logic       inst_unmapped, data_unmapped;

    function automatic logic in_kseg01(input vaddr_t va);
        return va >= `MMU_KSEG0_BASE && va <= `MMU_KSEG1_END;
    endfunction

    function automatic paddr_t strip_kseg(input vaddr_t va);
        if (va >= `MMU_KSEG1_BASE) begin
            return va - `MMU_KSEG1_BASE;
        end
        return va - `MMU_KSEG0_BASE;
    endfunction

    assign inst_unmapped = in_kseg01(inst_vaddr);
    assign data_unmapped = in_kseg01(data_vaddr);
    assign s1_vpn2       = probe_sel ? cp0_vpn2 : data_vaddr[31:13]; // TLBP borrows data port

    assign inst_paddr   = inst_unmapped ? strip_kseg(inst_vaddr)
                                        : {s0_lo.pfn, inst_vaddr[`MMU_PAGE_BITS-1:0]};
    assign inst_miss    = !inst_unmapped && !s0_found;
    assign inst_invalid = !inst_unmapped && s0_found && !s0_lo.v;

    assign data_paddr   = data_unmapped ? strip_kseg(data_vaddr)
                                        : {s1_lo.pfn, data_vaddr[`MMU_PAGE_BITS-1:0]};
    assign data_miss    = !data_unmapped && !s1_found;
    assign data_invalid = !data_unmapped && s1_found && !s1_lo.v;
    assign data_modify  = !data_unmapped && s1_found && s1_lo.v && data_store && !s1_lo.d;

    tlb tlb_inst (
        .clk      (clk),
        .reset    (reset),
        .s0_vpn2  (inst_vaddr[31:13]),
        .s0_odd   (inst_vaddr[12]),
        .s0_asid  (cp0_asid),
        .s0_found (s0_found),
        .s0_index (),
        .s0_lo    (s0_lo),
        .s1_vpn2  (s1_vpn2),
        .s1_odd   (data_vaddr[12]),
        .s1_asid  (cp0_asid),
        .s1_found (s1_found),
        .s1_index (s1_index),
        .s1_lo    (s1_lo),
        .we       (we),
        .w_index  (w_index),
        .w_vpn2   (cp0_vpn2),
        .w_asid   (cp0_asid),
        .w_g      (cp0_lo0.g & cp0_lo1.g), // global only if both halves say so
        .w_lo0    (cp0_lo0),
        .w_lo1    (cp0_lo1),
        .r_index  (cp0_index),
        .r_vpn2   (r_vpn2),
        .r_asid   (r_asid),
        .r_g      (r_g),
        .r_lo0    (r_lo0),
        .r_lo1    (r_lo1)
    );

    tlb_random tlb_random_inst (
        .clk          (clk),
        .reset        (reset),
        .wired        (cp0_wired),
        .wired_write  (wired_write),
        .random_index (random_index)
    );

    tlb_op_fsm tlb_op_fsm_inst (
        .clk          (clk),
        .reset        (reset),
        .op_req       (op_req),
        .op_code      (op_code),
        .cp0_index    (cp0_index),
        .random_index (random_index),
        .s1_found     (s1_found),
        .s1_index     (s1_index),
        .r_vpn2       (r_vpn2),
        .r_asid       (r_asid),
        .r_g          (r_g),
        .r_lo0        (r_lo0),
        .r_lo1        (r_lo1),
        .we           (we),
        .w_index      (w_index),
        .probe_sel    (probe_sel),
        .op_ack       (op_ack),
        .rd_vpn2      (rd_vpn2),
        .rd_asid      (rd_asid),
        .rd_lo0       (rd_lo0),
        .rd_lo1       (rd_lo1),
        .probe_hit    (probe_hit),
        .probe_index  (probe_index)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// free-running clock for the testbench, instantiate once and take clk from it
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end
endmodule

`default_nettype wire

// ==== testbench/tlb_mmu_chk.sv ====
// handshake and random index assertions, bound into the TLB operation FSM by the testbench
`timescale 1ns/1ns
`default_nettype none

module tlb_mmu_chk (
    input logic                      clk,
    input logic                      reset,
    input logic                      op_req,
    input logic                      op_ack,
    input tlb_entry_pkg::tlb_index_t random_index,
    input tlb_entry_pkg::tlb_index_t wired,
    input logic                      wired_write
);
    // requester holds op_req until it sees the ack
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(op_ack) |-> op_req)
        else $error("op_ack rose while op_req was low");

    ack_release: assert property (@(posedge clk) disable iff (reset)
        op_ack && !op_req |=> !op_ack)
        else $error("op_ack stayed high after op_req dropped");

    // bound may move under the counter in the cycle it is rewritten
    random_bound: assert property (@(posedge clk) disable iff (reset || wired_write)
        random_index >= wired)
        else $error("random index %0d below wired %0d", random_index, wired);

endmodule

`default_nettype wire

// ==== testbench/tlb_mmu_tb.sv ====
// testbench for the MMU, runs translations and TLB instructions against a shadow TLB model
`timescale 1ns/1ns
`default_nettype none
`include "mmu_defines.svh"

module tlb_mmu_tb;
    import tlb_entry_pkg::*;
    import tlb_op_pkg::*;

    localparam int entries    = `MMU_TLB_ENTRIES;
    localparam int max_cycles = 20000;

    logic       clk;
    logic       reset;
    vaddr_t     inst_vaddr, data_vaddr;
    logic       data_store, op_req, wired_write;
    tlb_op_t    op_code;
    tlb_index_t cp0_index, cp0_wired;
    vpn2_t      cp0_vpn2;
    asid_t      cp0_asid;
    tlb_lo_t    cp0_lo0, cp0_lo1;
    paddr_t     inst_paddr, data_paddr;
    logic       inst_miss, inst_invalid, data_miss, data_invalid, data_modify;
    logic       op_ack, probe_hit;
    vpn2_t      rd_vpn2;
    asid_t      rd_asid;
    tlb_lo_t    rd_lo0, rd_lo1;
    tlb_index_t probe_index;

    // what the testbench has written so far
    vpn2_t   sh_vpn2 [entries];
    asid_t   sh_asid [entries];
    logic    sh_g    [entries];
    tlb_lo_t sh_lo0  [entries];
    tlb_lo_t sh_lo1  [entries];

    vpn2_t      res_vpn2, e_vpn2;   // results held during ack, next entry to write
    asid_t      res_asid, e_asid;
    tlb_lo_t    res_lo0, res_lo1, e_lo0, e_lo1;
    logic       res_hit;
    tlb_index_t res_index;

    logic [31:0] lfsr     = 32'h33ee_0321;
    logic [7:0]  serial   = 8'd1;     // low VPN2 bits, keeps every written page unique
    logic        check_en = 1'b0;
    int op_errors = 0;
    int xlat_errors = 0;
    int cycles = 0;
    int tests = 0;
    int failed_tests = 0;
    int mark = 0;

    tb_clock #(.period(8)) clock_inst (.clk(clk));

    tlb_mmu tlb_mmu_inst (.*);

    bind tlb_op_fsm tlb_mmu_chk tlb_mmu_chk_inst (
        .clk          (clk),
        .reset        (reset),
        .op_req       (op_req),
        .op_ack       (op_ack),
        .random_index (random_index),
        .wired        (tlb_mmu_tb.tlb_mmu_inst.cp0_wired),
        .wired_write  (tlb_mmu_tb.tlb_mmu_inst.wired_write)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic vaddr_t mapped_va(input tlb_index_t k);
        return {sh_vpn2[k], 13'(take_bits(13))};
    endfunction

    function automatic vaddr_t miss_va();
        return {1'b0, 10'(take_bits(10)), 8'h00, 13'(take_bits(13))};
    endfunction

    function automatic asid_t pick_asid(input tlb_index_t k);
        if (take_bits(1) != 0) begin
            return sh_asid[k];
        end
        return asid_t'(take_bits(8));
    endfunction

    // expected translation from the shadow table
    function automatic void ref_translate(input vaddr_t va, input asid_t asid, input logic store,
                                          output paddr_t pa, output logic miss,
                                          output logic inv, output logic modify);
        tlb_lo_t lo;
        logic    hit;
        hit    = 1'b0;
        lo     = '0;
        miss   = 1'b0;
        inv    = 1'b0;
        modify = 1'b0;
        if (va[31:30] == 2'b10) begin
            pa = va - (va[29] ? `MMU_KSEG1_BASE : `MMU_KSEG0_BASE);
            return;
        end
        for (int i = 0; i < entries; i++) begin
            if (!hit && sh_vpn2[i] == va[31:13] && (sh_g[i] || sh_asid[i] == asid)) begin
                hit = 1'b1;
                lo  = va[12] ? sh_lo1[i] : sh_lo0[i];
            end
        end
        miss   = !hit;
        inv    = hit && !lo.v;
        modify = hit && lo.v && store && !lo.d;
        pa     = {lo.pfn, va[11:0]};
    endfunction

    task automatic compare_paddr(input string name, input paddr_t got, input paddr_t exp,
                                 inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp,
                                inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_lo(input string name, input tlb_lo_t got, input tlb_lo_t exp,
                              inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_vpn2(input string name, input vpn2_t got, input vpn2_t exp,
                                inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_asid(input string name, input asid_t got, input asid_t exp,
                                inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_index(input string name, input tlb_index_t got, input tlb_index_t exp,
                                 inout int errs);
        if (got !== exp) begin
            errs++;
            $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic gen_entry();
        e_vpn2 = {1'b0, 10'(take_bits(10)), serial};
        serial = serial + 8'd1;
        e_asid = asid_t'(take_bits(8));
        e_lo0  = tlb_lo_t'(take_bits(27));
        e_lo1  = tlb_lo_t'(take_bits(27));
    endtask

    task automatic shadow_store(input tlb_index_t idx);
        sh_vpn2[idx] = e_vpn2;
        sh_asid[idx] = e_asid;
        sh_g[idx]    = e_lo0.g & e_lo1.g;
        sh_lo0[idx]  = e_lo0;
        sh_lo1[idx]  = e_lo1;
    endtask

    // one four-phase operation, op_req held for hold extra cycles after the ack
    task automatic run_op(input tlb_op_t code, input tlb_index_t idx, input int hold);
        int n;
        @(posedge clk);
        #1;
        op_code   = code;
        cp0_index = idx;
        cp0_vpn2  = e_vpn2;
        cp0_asid  = e_asid;
        cp0_lo0   = e_lo0;
        cp0_lo1   = e_lo1;
        op_req    = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (!op_ack);
        if (n != 2) begin
            op_errors++;
            $display("Fail %0t op_ack latency got %0d edges expected 2", $time, n);
        end
        res_vpn2  = rd_vpn2;
        res_asid  = rd_asid;
        res_lo0   = rd_lo0;
        res_lo1   = rd_lo1;
        res_hit   = probe_hit;
        res_index = probe_index;
        repeat (hold) begin
            @(negedge clk);
            compare_flag("op_ack", op_ack, 1'b1, op_errors);
        end
        @(posedge clk);
        #1;
        op_req = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (op_ack);
        if (n != 1) begin
            op_errors++;
            $display("Fail %0t op_ack release got %0d edges expected 1", $time, n);
        end
    endtask

    task automatic translate(input vaddr_t iva, input vaddr_t dva, input logic store,
                             input asid_t asid);
        @(posedge clk);
        #1;
        inst_vaddr = iva;
        data_vaddr = dva;
        data_store = store;
        cp0_asid   = asid;
        check_en   = 1'b1;
    endtask

    task automatic stop_checks();
        @(posedge clk);
        #1;
        check_en = 1'b0;
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = op_errors + xlat_errors - mark;
        mark = op_errors + xlat_errors;
        tests++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %s done, %0d errors", name, errs);
    endtask

    // both ports against the reference, inputs are settled by the falling edge
    always @(negedge clk) begin : compare_proc
        paddr_t pa;
        logic   miss, inv, modify;
        if (check_en) begin
            ref_translate(inst_vaddr, cp0_asid, 1'b0, pa, miss, inv, modify);
            compare_flag("inst_miss", inst_miss, miss, xlat_errors);
            compare_flag("inst_invalid", inst_invalid, inv, xlat_errors);
            if (!miss && !inv) begin
                compare_paddr("inst_paddr", inst_paddr, pa, xlat_errors);
            end
            ref_translate(data_vaddr, cp0_asid, data_store, pa, miss, inv, modify);
            compare_flag("data_miss", data_miss, miss, xlat_errors);
            compare_flag("data_invalid", data_invalid, inv, xlat_errors);
            compare_flag("data_modify", data_modify, modify, xlat_errors);
            if (!miss && !inv) begin
                compare_paddr("data_paddr", data_paddr, pa, xlat_errors);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout, run went past %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        tlb_index_t k;
        tlb_index_t wired_bound;
        tlb_lo_t    exp_lo;
        inst_vaddr  = '0;
        data_vaddr  = '0;
        data_store  = 1'b0;
        op_req      = 1'b0;
        op_code     = TLB_OP_READ;
        cp0_index   = '0;
        cp0_vpn2    = '0;
        cp0_asid    = '0;
        cp0_lo0     = '0;
        cp0_lo1     = '0;
        cp0_wired   = '0;
        wired_write = 1'b0;
        reset       = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (4) begin
            @(negedge clk);
            compare_flag("op_ack", op_ack, 1'b0, op_errors);
        end
        for (int i = 0; i < 4; i++) begin
            gen_entry();
            run_op(TLB_OP_PROBE, '0, int'(take_bits(4)));   // long holds
        end
        report_test("handshake");

        for (int i = 0; i < 64; i++) begin
            translate({2'b10, 30'(take_bits(30))}, {2'b10, 30'(take_bits(30))},
                      1'(take_bits(1)), asid_t'(take_bits(8)));
        end
        stop_checks();
        report_test("unmapped");

        for (int i = 0; i < entries; i++) begin
            gen_entry();
            run_op(TLB_OP_WRITE_INDEX, tlb_index_t'(i), int'(take_bits(2)));
            shadow_store(tlb_index_t'(i));
        end
        for (int i = 0; i < 200; i++) begin
            k = tlb_index_t'(take_bits(4));
            translate(mapped_va(k), mapped_va(tlb_index_t'(take_bits(4))),
                      1'(take_bits(1)), pick_asid(k));
        end
        for (int i = 0; i < 16; i++) begin
            translate(miss_va(), miss_va(), 1'(take_bits(1)), asid_t'(take_bits(8)));
        end
        stop_checks();
        report_test("mapped");

        for (int i = 0; i < entries; i++) begin
            run_op(TLB_OP_READ, tlb_index_t'(i), int'(take_bits(2)));
            compare_vpn2("rd_vpn2", res_vpn2, sh_vpn2[i], op_errors);
            compare_asid("rd_asid", res_asid, sh_asid[i], op_errors);
            exp_lo   = sh_lo0[i];
            exp_lo.g = sh_g[i];
            compare_lo("rd_lo0", res_lo0, exp_lo, op_errors);
            exp_lo   = sh_lo1[i];
            exp_lo.g = sh_g[i];
            compare_lo("rd_lo1", res_lo1, exp_lo, op_errors);
        end
        report_test("tlbr");

        for (int i = 0; i < entries; i++) begin
            e_vpn2 = sh_vpn2[i];
            e_asid = sh_asid[i];
            run_op(TLB_OP_PROBE, '0, int'(take_bits(2)));
            compare_flag("probe_hit", res_hit, 1'b1, op_errors);
            compare_index("probe_index", res_index, tlb_index_t'(i), op_errors);
        end
        for (int i = 0; i < 4; i++) begin
            e_vpn2 = {1'b0, 10'(take_bits(10)), 8'h00};   // serial 0 is never written
            e_asid = asid_t'(take_bits(8));
            run_op(TLB_OP_PROBE, '0, int'(take_bits(2)));
            compare_flag("probe_hit", res_hit, 1'b0, op_errors);
        end
        report_test("tlbp");

        wired_bound = tlb_index_t'(take_bits(3)) + 4'd2;
        @(posedge clk);
        #1;
        cp0_wired   = wired_bound;
        wired_write = 1'b1;
        @(posedge clk);
        #1;
        wired_write = 1'b0;
        for (int i = 0; i < 12; i++) begin
            gen_entry();
            run_op(TLB_OP_WRITE_RANDOM, '0, int'(take_bits(3)));
            run_op(TLB_OP_PROBE, '0, int'(take_bits(2)));   // same entry-hi as the write
            compare_flag("probe_hit", res_hit, 1'b1, op_errors);
            if (res_hit && res_index < wired_bound) begin
                op_errors++;
                $display("TLBWR wrote index %0d, below the wired bound %0d", res_index,
                         wired_bound);
            end
            if (res_hit) begin
                shadow_store(res_index);
            end
        end
        for (int i = 0; i < 100; i++) begin
            k = tlb_index_t'(take_bits(4));
            translate(mapped_va(k), mapped_va(tlb_index_t'(take_bits(4))),
                      1'(take_bits(1)), pick_asid(k));
        end
        stop_checks();
        report_test("tlbwr");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests,
                 op_errors + xlat_errors);
        if (op_errors + xlat_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/tlb_entry_pkg.sv
hw/tlb_op_pkg.sv
hw/tlb.sv
hw/tlb_random.sv
hw/tlb_op_fsm.sv
hw/tlb_mmu.sv
testbench/tb_clock.sv
testbench/tlb_mmu_chk.sv
testbench/tlb_mmu_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tlb_mmu_tb
FILELIST := all.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
